//--- flist.f
common/attrib_pkg.sv
hdl/attrib_step.sv
persp/persp_divider.sv
persp/persp_correct.sv
hdl/attrib_interp.sv
tb/attrib_interp_sva.sv
tb/tb_attrib_interp.sv

//--- run.sh
#!/bin/sh
# Build and run the attribute interpolator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_attrib_interp -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

//--- tb/tb_attrib_interp.sv
`timescale 1ns/1ps

module tb_attrib_interp
    import attrib_pkg::*;
;

    localparam int div_width    = 32;
    localparam int init_x_beats = 4 * (1 + 12);
    localparam int y_step_beats = 3 * (1 + 5 * 7);
    localparam int nopix_beats  = 80;
    localparam int edge_beats   = 4 * (1 + 9);
    localparam int bp_beats     = 300;
    localparam int total_beats  = init_x_beats + y_step_beats + nopix_beats + edge_beats + bp_beats;

    logic      aclk;
    logic      rst_n;
    logic      s_valid;
    logic      s_ready;
    cmd_t      s_cmd;
    logic      s_pixel;
    pix_meta_t s_meta;
    attr_vec_t base;
    attr_vec_t inc_x;
    attr_vec_t inc_y;
    logic      m_valid;
    logic      m_ready;
    pix_meta_t m_meta;
    pix_out_t  m_pix;

    logic [31:0] rng = 32'h0c5cf741;
    logic        bp_on;
    string       cur_test;
    int          error_count;
    int          pix_sent;
    int          pix_checked;

    attr_vec_t tri_base;   // Triangle setup applied at the next accepted beat
    attr_vec_t tri_inc_x;
    attr_vec_t tri_inc_y;
    attr_vec_t row_m;      // Model accumulators
    attr_vec_t cur_m;

    pix_out_t  exp_pix_q[$];
    pix_meta_t exp_meta_q[$];
    string     exp_name_q[$];

    attrib_interp #(
        .DIV_WIDTH(div_width)
    ) i_dut (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .s_valid(s_valid),
        .s_ready(s_ready),
        .s_cmd  (s_cmd),
        .s_pixel(s_pixel),
        .s_meta (s_meta),
        .base   (base),
        .inc_x  (inc_x),
        .inc_y  (inc_y),
        .m_valid(m_valid),
        .m_ready(m_ready),
        .m_meta (m_meta),
        .m_pix  (m_pix)
    );

    bind attrib_interp attrib_interp_sva i_sva (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .m_valid(m_valid),
        .m_ready(m_ready),
        .m_meta (m_meta),
        .m_pix  (m_pix)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // xorshift32
    function automatic logic [31:0] rand_next();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic attr_vec_t rand_vec();
        attr_vec_t v;
        for (int i = 0; i < 9; i++) begin
            v[i*32 +: 32] = rand_next();
        end
        return v;
    endfunction

    function automatic pix_meta_t rand_meta();
        pix_meta_t   m;
        logic [31:0] r;
        r       = rand_next();
        m.last  = r[0];
        m.spx   = r[11:1];
        m.spy   = r[22:12];
        m.index = rand_next();
        return m;
    endfunction

    function automatic attr_vec_t add_words(input attr_vec_t x, input attr_vec_t y);
        attr_vec_t v;
        for (int i = 0; i < 9; i++) begin
            v[i*32 +: 32] = x[i*32 +: 32] + y[i*32 +: 32];
        end
        return v;
    endfunction

    // (n << 15) / d, truncated, saturated on a zero divisor
    function automatic logic [31:0] div_model(input logic signed [31:0] n,
                                              input logic signed [31:0] d);
        longint num;
        longint quo;
        if (d == 0) begin
            return n[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end
        num = longint'(n) <<< frac_bits;
        quo = num / longint'(d);
        return quo[31:0];
    endfunction

    // Integer part of S7.24 never reaches 256
    function automatic logic [7:0] clamp_model(input logic signed [31:0] v);
        if (v < 0) begin
            return 8'd0;
        end
        return v[31:24];
    endfunction

    function automatic pix_out_t build_expected(input attr_vec_t c);
        pix_out_t e;
        e.tex_s   = div_model(c.s, c.q);
        e.tex_t   = div_model(c.t, c.q);
        e.depth_w = c.w;
        e.depth_z = c.z;
        e.col_r   = clamp_model(c.r);
        e.col_g   = clamp_model(c.g);
        e.col_b   = clamp_model(c.b);
        e.col_a   = clamp_model(c.a);
        return e;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic apply_model(input cmd_t cmd, input logic pixel, input pix_meta_t meta);
        case (cmd)
            cmd_init: begin
                row_m = tri_base;
                cur_m = tri_base;
            end
            cmd_inc_x: cur_m = add_words(cur_m, tri_inc_x);
            cmd_inc_y: begin
                row_m = add_words(row_m, tri_inc_y);
                cur_m = row_m;
            end
            default: ;
        endcase
        if (pixel) begin
            exp_pix_q.push_back(build_expected(cur_m));
            exp_meta_q.push_back(meta);
            exp_name_q.push_back(cur_test);
            pix_sent++;
        end
    endtask

    // Retries until the beat is taken
    // Stall and idle slots carry junk
    task automatic drive_beat(input cmd_t cmd, input logic pixel);
        logic [31:0] r;
        logic        taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge aclk);
            r       = rand_next();
            m_ready = bp_on ? (r[1:0] != 2'd0) : 1'b1;
            if (m_ready && !(bp_on && r[4:2] == 3'd0)) begin
                s_valid = 1'b1;
                s_cmd   = cmd;
                s_pixel = pixel;
                s_meta  = rand_meta();
                base    = tri_base;
                inc_x   = tri_inc_x;
                inc_y   = tri_inc_y;
                apply_model(cmd, pixel, s_meta);
                taken = 1'b1;
            end else begin
                s_valid = !m_ready && r[5];
                s_cmd   = cmd_t'(r[7:6]);
                s_pixel = r[8];
                s_meta  = rand_meta();
            end
        end
    endtask

    task automatic new_triangle();
        tri_base  = rand_vec();
        tri_inc_x = rand_vec();
        tri_inc_y = rand_vec();
    endtask

    // q through zero or negative, colours over both clamp limits
    task automatic edge_triangle(input int k);
        new_triangle();
        tri_base.r  = -32'sh0100_0000;
        tri_inc_x.r = 32'sh0040_0000;   // Climbs out of the negative range
        tri_base.g  = 32'sh7e00_0000;
        tri_inc_x.g = 32'sh0080_0000;   // Wraps past the top
        tri_inc_x.q = 32'sd1;
        case (k)
            0: tri_base.q = -32'sd4;
            1: begin
                tri_base.q  = 32'sd0;
                tri_inc_x.q = 32'sd0;
                tri_base.s  = 32'sd0;
                tri_inc_x.s = 32'sd0;
                tri_base.t  = -32'sd77;
                tri_inc_x.t = -32'sd5;
            end
            2: begin
                tri_base.q  = -32'sd1000;
                tri_inc_x.q = -32'sd3;
            end
            default: begin
                tri_base.q  = 32'sd3;
                tri_inc_x.q = -32'sd1;
            end
        endcase
    endtask

    always @(posedge aclk) begin : check_out
        pix_out_t  e;
        pix_meta_t em;
        string     name;
        check_value({cur_test, " s_ready"}, 64'(m_ready), 64'(s_ready));
        if (rst_n && m_valid && m_ready) begin
            pix_checked++;
            if (exp_pix_q.size() == 0) begin
                $display("Error: DUT sent an output beat while no pixel was expected");
                error_count++;
            end else begin
                e    = exp_pix_q.pop_front();
                em   = exp_meta_q.pop_front();
                name = exp_name_q.pop_front();
                check_value({name, " meta"}, 64'(em), 64'(m_meta));
                check_value({name, " tex_s"}, 64'(e.tex_s), 64'(m_pix.tex_s));
                check_value({name, " tex_t"}, 64'(e.tex_t), 64'(m_pix.tex_t));
                check_value({name, " depth_w"}, 64'(e.depth_w), 64'(m_pix.depth_w));
                check_value({name, " depth_z"}, 64'(e.depth_z), 64'(m_pix.depth_z));
                check_value({name, " colour"}, 64'({e.col_r, e.col_g, e.col_b, e.col_a}),
                            64'({m_pix.col_r, m_pix.col_g, m_pix.col_b, m_pix.col_a}));
            end
        end
    end

    initial begin : watchdog
        repeat (total_beats * 4 + div_width + 100) @(posedge aclk);
        $display("Error: watchdog fired, the run did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int          drain;
        logic [31:0] r;
        rst_n   = 1'b0;
        s_valid = 1'b0;
        s_cmd   = cmd_nop;
        s_pixel = 1'b0;
        s_meta  = '0;
        base    = '0;
        inc_x   = '0;
        inc_y   = '0;
        m_ready = 1'b1;
        bp_on   = 1'b0;
        repeat (3) @(negedge aclk);
        rst_n = 1'b1;

        cur_test = "init_x";
        for (int n = 0; n < 4; n++) begin
            new_triangle();
            drive_beat(cmd_init, 1'b1);
            repeat (12) drive_beat(cmd_inc_x, 1'b1);
        end

        cur_test = "y_step";
        for (int n = 0; n < 3; n++) begin
            new_triangle();
            drive_beat(cmd_init, 1'b1);
            for (int row = 0; row < 5; row++) begin
                repeat (6) drive_beat(cmd_inc_x, 1'b1);
                drive_beat(cmd_inc_y, 1'b1);
            end
        end

        cur_test = "non_pixel";
        new_triangle();
        drive_beat(cmd_init, 1'b0);
        for (int n = 1; n < nopix_beats; n++) begin
            r = rand_next();
            drive_beat(cmd_t'(r[1:0]), r[2]);
        end

        cur_test = "edge";
        for (int k = 0; k < 4; k++) begin
            edge_triangle(k);
            drive_beat(cmd_init, 1'b1);
            repeat (9) drive_beat(cmd_inc_x, 1'b1);
        end

        cur_test = "backpressure";
        bp_on    = 1'b1;
        for (int n = 0; n < bp_beats; n++) begin
            r = rand_next();
            if (n % 25 == 0) begin
                new_triangle();
                drive_beat(cmd_init, 1'b1);
            end else begin
                drive_beat((r[1:0] == 2'd0) ? cmd_inc_y : cmd_inc_x, r[4:2] != 3'd0);
            end
        end

        // Drain, then leave time for any duplicate beat to show up
        @(negedge aclk);
        bp_on   = 1'b0;
        s_valid = 1'b0;
        m_ready = 1'b1;
        drain   = 0;
        while (exp_pix_q.size() != 0 && drain < 2 * div_width + 20) begin
            @(posedge aclk);
            drain++;
        end
        repeat (div_width + 4) @(posedge aclk);
        if (exp_pix_q.size() != 0) begin
            $display("Error: %0d expected pixels never came out of the DUT", exp_pix_q.size());
            error_count++;
        end
        check_value("final pixel count", 64'(pix_sent), 64'(pix_checked));

        $display("Errors: %0d, pixels sent: %0d, pixels checked: %0d",
                 error_count, pix_sent, pix_checked);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- tb/attrib_interp_sva.sv
`timescale 1ns/1ps

// Output stream properties of the interpolator
module attrib_interp_sva
    import attrib_pkg::*;
(
    input logic      aclk,
    input logic      rst_n,
    input logic      m_valid,
    input logic      m_ready,
    input pix_meta_t m_meta,
    input pix_out_t  m_pix
);

    // No output beat while reset is held
    a_reset_quiet: assert property (@(posedge aclk) !rst_n && $past(!rst_n) |-> !m_valid)
        else $error("m_valid high during reset");

    // Whole pipe freezes with m_ready low
    a_hold_valid: assert property (@(posedge aclk) disable iff (!rst_n)
        !m_ready |=> $stable(m_valid))
        else $error("m_valid changed while m_ready was low");

    a_hold_meta: assert property (@(posedge aclk) disable iff (!rst_n)
        m_valid && !m_ready |=> $stable(m_meta))
        else $error("m_meta changed while stalled");

    a_hold_pix: assert property (@(posedge aclk) disable iff (!rst_n)
        m_valid && !m_ready |=> $stable(m_pix))
        else $error("m_pix changed while stalled");

endmodule

//--- hdl/attrib_interp.sv
`timescale 1ns/1ps

// Per-pixel attribute interpolator.
// Latency is DIV_WIDTH + 2 cycles, the whole pipe stalls with m_ready.
module attrib_interp
    import attrib_pkg::*;
#(
    parameter int DIV_WIDTH = 32
) (
    input  logic      aclk,
    input  logic      rst_n,

    // Rasterizer stream
    input  logic      s_valid,
    output logic      s_ready,
    input  cmd_t      s_cmd,
    input  logic      s_pixel,
    input  pix_meta_t s_meta,

    // Triangle attributes, static per triangle
    input  attr_vec_t base,
    input  attr_vec_t inc_x,
    input  attr_vec_t inc_y,

    // Interpolated pixel stream
    output logic      m_valid,
    input  logic      m_ready,
    output pix_meta_t m_meta,
    output pix_out_t  m_pix
);

    logic      ce;
    logic      step_valid;
    pix_meta_t step_meta;
    attr_vec_t step_cur;

    assign ce      = m_ready;  // No skid buffer, downstream ready stalls all stages
    assign s_ready = m_ready;

    attrib_step i_step (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .ce       (ce),
        .valid    (s_valid),
        .cmd      (s_cmd),
        .pixel    (s_pixel),
        .meta     (s_meta),
        .base     (base),
        .inc_x    (inc_x),
        .inc_y    (inc_y),
        .out_valid(step_valid),
        .out_meta (step_meta),
        .cur      (step_cur)
    );

    persp_correct #(
        .DIV_WIDTH(DIV_WIDTH)
    ) i_persp (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .ce       (ce),
        .in_valid (step_valid),
        .in_meta  (step_meta),
        .cur      (step_cur),
        .out_valid(m_valid),
        .out_meta (m_meta),
        .pix      (m_pix)
    );

endmodule

//--- persp/persp_correct.sv
`timescale 1ns/1ps

// Perspective correction of s and t by q, colour clamping and the
// sideband delay that keeps everything aligned with the dividers
module persp_correct
    import attrib_pkg::*;
#(
    parameter int DIV_WIDTH = 32
) (
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      ce,

    input  logic      in_valid,
    input  pix_meta_t in_meta,
    input  attr_vec_t cur,

    output logic      out_valid,
    output pix_meta_t out_meta,
    output pix_out_t  pix
);

    // Everything that bypasses the dividers
    typedef struct packed {
        pix_meta_t         meta;
        logic [attr_w-1:0] w;
        logic [attr_w-1:0] z;
        logic [attr_w-1:0] r;
        logic [attr_w-1:0] g;
        logic [attr_w-1:0] b;
        logic [attr_w-1:0] a;
    } side_t;

    side_t                side_in;
    side_t                side_sr [DIV_WIDTH];
    side_t                side_out;
    logic [DIV_WIDTH-1:0] valid_sr;
    logic [DIV_WIDTH-1:0] quot_s;
    logic [DIV_WIDTH-1:0] quot_t;
    pix_out_t             pix_nxt;

    // S7.24 to 8 bit
    function automatic logic [7:0] clamp_col(input logic signed [attr_w-1:0] v);
        logic signed [attr_w-1:0] ipart;
        ipart = v >>> col_frac;
        if (ipart < 0) begin
            return 8'd0;
        end
        return ipart[7:0];  // S7.24 tops out at 127
    endfunction

    persp_divider #(
        .DIV_WIDTH(DIV_WIDTH)
    ) i_div_s (
        .aclk (aclk),
        .rst_n(rst_n),
        .ce   (ce),
        .num  (cur.s),
        .den  (cur.q),
        .quot (quot_s)
    );

    persp_divider #(
        .DIV_WIDTH(DIV_WIDTH)
    ) i_div_t (
        .aclk (aclk),
        .rst_n(rst_n),
        .ce   (ce),
        .num  (cur.t),
        .den  (cur.q),
        .quot (quot_t)
    );

    assign side_in = '{meta: in_meta, w: cur.w, z: cur.z,
                       r: cur.r, g: cur.g, b: cur.b, a: cur.a};

    // Delay lines as deep as the dividers
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else if (ce) begin
            valid_sr <= (valid_sr << 1) | DIV_WIDTH'(in_valid);
        end
    end

    always_ff @(posedge aclk) begin
        if (ce) begin
            side_sr[0] <= side_in;
            for (int i = 1; i < DIV_WIDTH; i++) begin
                side_sr[i] <= side_sr[i-1];
            end
        end
    end

    assign side_out = side_sr[DIV_WIDTH-1];

    always_comb begin
        pix_nxt.tex_s   = attr_w'(signed'(quot_s));  // Sign extend when narrower
        pix_nxt.tex_t   = attr_w'(signed'(quot_t));
        pix_nxt.depth_w = side_out.w;
        pix_nxt.depth_z = side_out.z;
        pix_nxt.col_r   = clamp_col(side_out.r);
        pix_nxt.col_g   = clamp_col(side_out.g);
        pix_nxt.col_b   = clamp_col(side_out.b);
        pix_nxt.col_a   = clamp_col(side_out.a);
    end

    // Output register
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (ce) begin
            out_valid <= valid_sr[DIV_WIDTH-1];
        end
    end

    always_ff @(posedge aclk) begin
        if (ce) begin
            out_meta <= side_out.meta;
            pix      <= pix_nxt;
        end
    end

endmodule

//--- persp/persp_divider.sv
`timescale 1ns/1ps

// Pipelined signed restoring divider, (num << frac_bits) / den.
// One quotient bit per stage, DIV_WIDTH stages deep.
module persp_divider
    import attrib_pkg::*;
#(
    parameter int DIV_WIDTH = 32
) (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic                     ce,
    input  logic signed [attr_w-1:0] num,
    input  logic signed [attr_w-1:0] den,
    output logic [DIV_WIDTH-1:0]     quot
);

    // Extended dividend is never narrower than the quotient
    localparam int ext_w = (attr_w + frac_bits > DIV_WIDTH) ? attr_w + frac_bits : DIV_WIDTH;
    localparam logic [DIV_WIDTH-1:0] q_max = {1'b0, {(DIV_WIDTH-1){1'b1}}};
    localparam logic [DIV_WIDTH-1:0] q_min = {1'b1, {(DIV_WIDTH-1){1'b0}}};

    typedef struct packed {
        logic [attr_w-1:0]    rem;
        logic [DIV_WIDTH-1:0] dq;   // Dividend bits out at the top, quotient bits in below
        logic [attr_w-1:0]    den;
    } div_data_t;

    typedef struct packed {
        logic neg;   // Result sign
        logic zero;  // Divide by zero
        logic pos;   // Numerator not negative
    } div_flag_t;

    logic [attr_w-1:0] num_mag;
    logic [attr_w-1:0] den_mag;
    logic [ext_w-1:0]  dvd_ext;
    logic [attr_w-1:0] rem_pre;
    div_data_t         first_d;
    div_flag_t         first_f;
    div_data_t         last_d;
    div_flag_t         last_f;

    assign num_mag = num[attr_w-1] ? -num : num;
    assign den_mag = den[attr_w-1] ? -den : den;
    assign dvd_ext = ext_w'({num_mag, {frac_bits{1'b0}}});

    // Dividend bits above the quotient width only set the starting remainder.
    // Their quotient bits fall off in the truncation anyway.
    always_comb begin
        logic [attr_w:0] trial;
        trial   = '0;
        rem_pre = '0;
        for (int i = ext_w - 1; i >= DIV_WIDTH; i--) begin
            trial = {rem_pre, dvd_ext[i]};
            if (trial >= {1'b0, den_mag}) begin
                trial = trial - {1'b0, den_mag};
            end
            rem_pre = trial[attr_w-1:0];
        end
    end

    assign first_d = '{rem: rem_pre, dq: dvd_ext[DIV_WIDTH-1:0], den: den_mag};
    assign first_f = '{neg: num[attr_w-1] ^ den[attr_w-1], zero: (den == '0),
                       pos: ~num[attr_w-1]};

    for (genvar k = 0; k < DIV_WIDTH; k++) begin : g_stage
        div_data_t         src_d;
        div_flag_t         src_f;
        div_data_t         data_q;
        div_flag_t         flag_q;
        logic [attr_w:0]   trial;
        logic [attr_w:0]   diff;

        if (k == 0) begin : g_first
            assign src_d = first_d;
            assign src_f = first_f;
        end else begin : g_next
            assign src_d = g_stage[k-1].data_q;
            assign src_f = g_stage[k-1].flag_q;
        end

        assign trial = {src_d.rem, src_d.dq[DIV_WIDTH-1]};
        assign diff  = trial - {1'b0, src_d.den};  // Top bit set means no subtract

        always_ff @(posedge aclk) begin
            if (ce) begin
                data_q.rem <= diff[attr_w] ? trial[attr_w-1:0] : diff[attr_w-1:0];
                data_q.dq  <= {src_d.dq[DIV_WIDTH-2:0], ~diff[attr_w]};
                data_q.den <= src_d.den;
            end
        end

        always_ff @(posedge aclk or negedge rst_n) begin
            if (!rst_n) begin
                flag_q <= '0;
            end else if (ce) begin
                flag_q <= src_f;
            end
        end
    end

    assign last_d = g_stage[DIV_WIDTH-1].data_q;
    assign last_f = g_stage[DIV_WIDTH-1].flag_q;

    // Sign back on, saturate when q was zero
    always_comb begin
        if (last_f.zero) begin
            quot = last_f.pos ? q_max : q_min;
        end else if (last_f.neg) begin
            quot = -last_d.dq;
        end else begin
            quot = last_d.dq;
        end
    end

endmodule

//--- hdl/attrib_step.sv
`timescale 1ns/1ps

// Incremental attribute stepping driven by the rasterizer commands.
// The row accumulators remember the start of the current line, the
// current accumulators walk along it.
module attrib_step
    import attrib_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      ce,

    input  logic      valid,
    input  cmd_t      cmd,
    input  logic      pixel,
    input  pix_meta_t meta,

    input  attr_vec_t base,
    input  attr_vec_t inc_x,
    input  attr_vec_t inc_y,

    output logic      out_valid,
    output pix_meta_t out_meta,
    output attr_vec_t cur
);

    attr_vec_t row_acc;
    attr_vec_t row_next;

    // Word-wise add, no carry between attributes
    function automatic attr_vec_t vec_add(input attr_vec_t x, input attr_vec_t y);
        attr_vec_t sum;
        sum = '0;
        for (int i = 0; i < attr_cnt; i++) begin
            sum[i*attr_w +: attr_w] = x[i*attr_w +: attr_w] + y[i*attr_w +: attr_w];
        end
        return sum;
    endfunction

    assign row_next = vec_add(row_acc, inc_y);

    // cur doubles as the output register of this stage
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            row_acc <= '0;
            cur     <= '0;
        end else if (ce && valid) begin
            unique case (cmd)
                cmd_init: begin
                    row_acc <= base;
                    cur     <= base;
                end
                cmd_inc_x: begin
                    cur <= vec_add(cur, inc_x);
                end
                cmd_inc_y: begin
                    // New line starts from the row value, not from cur
                    row_acc <= row_next;
                    cur     <= row_next;
                end
                default: ;  // cmd_nop
            endcase
        end
    end

    // Only pixel beats travel on
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (ce) begin
            out_valid <= valid & pixel;
        end
    end

    always_ff @(posedge aclk) begin
        if (ce) begin
            out_meta <= meta;
        end
    end

endmodule

//--- common/attrib_pkg.sv
// Shared types and widths for the attribute interpolator
package attrib_pkg;

    localparam int attr_w    = 32;  // Fixed-point attribute and increment width
    localparam int frac_bits = 15;  // Fraction bits of the corrected texture coords
    localparam int pos_w     = 11;  // Screen coordinate width
    localparam int index_w   = 32;  // Framebuffer pixel index
    localparam int attr_cnt  = 9;   // Words in attr_vec_t
    localparam int col_frac  = 24;  // Colour accumulators are S7.24

    // Rasterizer commands
    typedef enum logic [1:0] {
        cmd_init  = 2'd0,  // Load base into row and current
        cmd_inc_x = 2'd1,  // Step current in x
        cmd_inc_y = 2'd2,  // Step row in y, restart current from it
        cmd_nop   = 2'd3
    } cmd_t;

    // Sideband of one beat, 55 bits
    typedef struct packed {
        logic               last;
        logic [pos_w-1:0]   spx;
        logic [pos_w-1:0]   spy;
        logic [index_w-1:0] index;
    } pix_meta_t;

    // One word per attribute
    // Texture S3.28, depth S1.30, colour S7.24
    typedef struct packed {
        logic signed [attr_w-1:0] s;
        logic signed [attr_w-1:0] t;
        logic signed [attr_w-1:0] q;
        logic signed [attr_w-1:0] w;
        logic signed [attr_w-1:0] z;
        logic signed [attr_w-1:0] r;
        logic signed [attr_w-1:0] g;
        logic signed [attr_w-1:0] b;
        logic signed [attr_w-1:0] a;
    } attr_vec_t;

    // Interpolated pixel
    typedef struct packed {
        logic [attr_w-1:0] tex_s;    // S16.15
        logic [attr_w-1:0] tex_t;    // S16.15
        logic [attr_w-1:0] depth_w;
        logic [attr_w-1:0] depth_z;
        logic [7:0]        col_r;
        logic [7:0]        col_g;
        logic [7:0]        col_b;
        logic [7:0]        col_a;
    } pix_out_t;

endpackage
